/* Makefile */
# Verilator flow for the pipelined MIPS core
TOP       ?= tb_main
FLIST     ?= mips_pipe.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

# A nonzero simulator status or the fail message in the log fails the target
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Testbench failed" $(LOG); then \
		echo "Simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* mips_pipe.f */
source/mips_pkg.sv
source/main_control.sv
source/instruction_fetch.sv
source/instruction_decode.sv
source/execute.sv
source/memory_access.sv
source/main.sv
tb/tb_main.sv

/* source/execute.sv */
`timescale 1ns/1ps
`default_nettype none

module execute (
	input  logic        clk,
	input  logic        reset,
	input  logic        ex_reg_dest,
	input  logic        ex_branch,
	input  logic        ex_mem_read,
	input  logic        ex_mem_to_reg,
	input  logic        ex_mem_write,
	input  logic        ex_alu_src,
	input  logic        ex_reg_write,
	input  logic [1:0]  ex_alu_op,
	input  logic [31:0] ex_pc_plus4,
	input  logic [31:0] read_data_1,
	input  logic [31:0] read_data_2,
	input  logic [31:0] ext_imm,
	input  logic [4:0]  rt,
	input  logic [4:0]  rd,
	output logic [31:0] alu_result,
	output logic        zero,
	output logic [31:0] branch_target,
	output logic [31:0] store_data,
	output logic [4:0]  dest_reg,
	output logic        reg_write,
	output logic        mem_to_reg,
	output logic        mem_read,
	output logic        mem_write,
	output logic        branch
);
	import mips_pkg::*;

	logic [2:0]  alu_ctl;
	logic [31:0] operand_b;
	logic [31:0] result;

	always_comb begin
		alu_ctl = ALU_ADD;
		case (ex_alu_op)
			ALUOP_BEQ: alu_ctl = ALU_SUB;
			ALUOP_FUNCT: begin
				case (ext_imm[5:0]) // funct field of the R-format word
					FN_SUB:  alu_ctl = ALU_SUB;
					FN_AND:  alu_ctl = ALU_AND;
					FN_OR:   alu_ctl = ALU_OR;
					FN_SLT:  alu_ctl = ALU_SLT;
					default: alu_ctl = ALU_ADD; // Also the all-zero nop
				endcase
			end
			default: alu_ctl = ALU_ADD; // lw, sw and addi
		endcase
	end

	assign operand_b = ex_alu_src ? ext_imm : read_data_2;

	always_comb begin
		case (alu_ctl)
			ALU_SUB: result = read_data_1 - operand_b;
			ALU_AND: result = read_data_1 & operand_b;
			ALU_OR:  result = read_data_1 | operand_b;
			ALU_SLT: result = {31'd0, $signed(read_data_1) < $signed(operand_b)};
			default: result = read_data_1 + operand_b;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			alu_result    <= '0;
			zero          <= 1'b0;
			branch_target <= '0;
			store_data    <= '0;
			dest_reg      <= '0;
			reg_write     <= 1'b0;
			mem_to_reg    <= 1'b0;
			mem_read      <= 1'b0;
			mem_write     <= 1'b0;
			branch        <= 1'b0;
		end else begin
			alu_result    <= result;
			zero          <= (result == 32'd0);
			branch_target <= ex_pc_plus4 + {ext_imm[29:0], 2'b00}; // Word offset
			store_data    <= read_data_2;
			dest_reg      <= ex_reg_dest ? rd : rt;
			reg_write     <= ex_reg_write;
			mem_to_reg    <= ex_mem_to_reg;
			mem_read      <= ex_mem_read;
			mem_write     <= ex_mem_write;
			branch        <= ex_branch;
		end
	end

	// Control and funct arrive through two register stages
	alu_ctl_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(alu_ctl))
		else $error("ALU operation unknown");

endmodule

`default_nettype wire

/* source/instruction_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module instruction_decode (
	input  logic             clk,
	input  logic             reset,
	input  mips_pkg::instr_t next_instruction,
	input  logic [31:0]      pc_plus4,
	input  logic             reg_dest,
	input  logic             branch,
	input  logic             mem_read,
	input  logic             mem_to_reg,
	input  logic             mem_write,
	input  logic             alu_src,
	input  logic             reg_write,
	input  logic [1:0]       alu_op,
	input  logic [31:0]      wb_data,
	input  logic [4:0]       wb_reg,
	input  logic             wb_write,
	output logic             ex_reg_dest,
	output logic             ex_branch,
	output logic             ex_mem_read,
	output logic             ex_mem_to_reg,
	output logic             ex_mem_write,
	output logic             ex_alu_src,
	output logic             ex_reg_write,
	output logic [1:0]       ex_alu_op,
	output logic [31:0]      ex_pc_plus4,
	output logic [31:0]      read_data_1,
	output logic [31:0]      read_data_2,
	output logic [31:0]      ext_imm,
	output logic [4:0]       rt,
	output logic [4:0]       rd
);
	import mips_pkg::*;

	logic [31:0] regs [NUM_REGS];
	logic [31:0] rs_value;
	logic [31:0] rt_value;

	// Write-first so the writer's value is visible in the same cycle
	function automatic logic [31:0] read_port(input logic [4:0] idx);
		if (idx == 5'd0)
			return 32'd0;
		if (wb_write && wb_reg == idx)
			return wb_data;
		return regs[idx];
	endfunction

	always_comb begin
		rs_value = read_port(next_instruction.r.rs);
		rt_value = read_port(next_instruction.r.rt);
	end

	always_ff @(posedge clk) begin
		if (wb_write && wb_reg != 5'd0)
			regs[wb_reg] <= wb_data; // r0 stays zero
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ex_reg_dest   <= 1'b0;
			ex_branch     <= 1'b0;
			ex_mem_read   <= 1'b0;
			ex_mem_to_reg <= 1'b0;
			ex_mem_write  <= 1'b0;
			ex_alu_src    <= 1'b0;
			ex_reg_write  <= 1'b0;
			ex_alu_op     <= '0;
			ex_pc_plus4   <= '0;
			read_data_1   <= '0;
			read_data_2   <= '0;
			ext_imm       <= '0;
			rt            <= '0;
			rd            <= '0;
		end else begin
			ex_reg_dest   <= reg_dest;
			ex_branch     <= branch;
			ex_mem_read   <= mem_read;
			ex_mem_to_reg <= mem_to_reg;
			ex_mem_write  <= mem_write;
			ex_alu_src    <= alu_src;
			ex_reg_write  <= reg_write;
			ex_alu_op     <= alu_op;
			ex_pc_plus4   <= pc_plus4;
			read_data_1   <= rs_value;
			read_data_2   <= rt_value;
			ext_imm       <= {{16{next_instruction.i.imm[15]}}, next_instruction.i.imm};
			rt            <= next_instruction.r.rt;
			rd            <= next_instruction.r.rd;
		end
	end

endmodule

`default_nettype wire

/* source/instruction_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module instruction_fetch (
	input  logic             clk,
	input  logic             reset,
	input  logic [7:0]       instruction_mem [mips_pkg::IMEM_BYTES-1:0],
	input  logic             pc_src,
	input  logic [31:0]      branch_target,
	output mips_pkg::instr_t next_instruction,
	output logic [31:0]      pc_plus4
);
	import mips_pkg::*;

	logic [31:0]                   pc;
	logic [$clog2(IMEM_BYTES)-1:2] word_addr;
	logic [31:0]                   fetch_word;

	assign word_addr = pc[$clog2(IMEM_BYTES)-1:2];

	// Most significant byte sits at the lowest address
	assign fetch_word = {instruction_mem[{word_addr, 2'd0}],
		instruction_mem[{word_addr, 2'd1}],
		instruction_mem[{word_addr, 2'd2}],
		instruction_mem[{word_addr, 2'd3}]};

	always_ff @(posedge clk) begin
		if (reset) begin
			pc               <= '0;
			next_instruction <= '0;
			pc_plus4         <= '0;
		end else begin
			next_instruction <= fetch_word; // IF/ID stage register
			pc_plus4         <= pc + 32'd4;
			if (pc_src)
				pc <= branch_target; // Taken beq from memory stage
			else
				pc <= pc + 32'd4;
		end
	end

	// Branch targets come back from execute as offsets times four
	pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
		else $error("PC not word aligned: %h", pc);

endmodule

`default_nettype wire

/* source/main.sv */
`timescale 1ns/1ps
`default_nettype none

module main (
	input  logic             clk,
	input  logic             reset,
	input  logic [7:0]       instruction_mem [mips_pkg::IMEM_BYTES-1:0],
	output mips_pkg::instr_t next_instruction,
	output logic [31:0]      alu_result
);
	logic [31:0] pc_plus4;
	logic        ctrl_reg_dest, ctrl_branch, ctrl_mem_read, ctrl_mem_to_reg;
	logic        ctrl_mem_write, ctrl_alu_src, ctrl_reg_write;
	logic [1:0]  ctrl_alu_op;
	logic        ex_reg_dest, ex_branch, ex_mem_read, ex_mem_to_reg;
	logic        ex_mem_write, ex_alu_src, ex_reg_write;
	logic [1:0]  ex_alu_op;
	logic [31:0] ex_pc_plus4, read_data_1, read_data_2, ext_imm;
	logic [4:0]  ex_rt, ex_rd;
	logic        em_zero, em_reg_write, em_mem_to_reg, em_mem_read, em_mem_write, em_branch;
	logic [31:0] em_branch_target, em_store_data;
	logic [4:0]  em_dest_reg;
	logic        pc_src, wb_write;
	logic [31:0] wb_data;
	logic [4:0]  wb_reg;

	main_control ctrl (.opcode(next_instruction.r.opcode), .reg_dest(ctrl_reg_dest),
		.branch(ctrl_branch), .mem_read(ctrl_mem_read), .mem_to_reg(ctrl_mem_to_reg),
		.mem_write(ctrl_mem_write), .alu_src(ctrl_alu_src), .reg_write(ctrl_reg_write),
		.alu_op(ctrl_alu_op));

	instruction_fetch if_stage (.clk, .reset, .instruction_mem, .pc_src,
		.branch_target(em_branch_target), .next_instruction, .pc_plus4);

	instruction_decode id_stage (.clk, .reset, .next_instruction, .pc_plus4,
		.reg_dest(ctrl_reg_dest), .branch(ctrl_branch), .mem_read(ctrl_mem_read),
		.mem_to_reg(ctrl_mem_to_reg), .mem_write(ctrl_mem_write), .alu_src(ctrl_alu_src),
		.reg_write(ctrl_reg_write), .alu_op(ctrl_alu_op), .wb_data, .wb_reg, .wb_write,
		.ex_reg_dest, .ex_branch, .ex_mem_read, .ex_mem_to_reg, .ex_mem_write,
		.ex_alu_src, .ex_reg_write, .ex_alu_op, .ex_pc_plus4, .read_data_1,
		.read_data_2, .ext_imm, .rt(ex_rt), .rd(ex_rd));

	execute ex_stage (.clk, .reset, .ex_reg_dest, .ex_branch, .ex_mem_read,
		.ex_mem_to_reg, .ex_mem_write, .ex_alu_src, .ex_reg_write, .ex_alu_op,
		.ex_pc_plus4, .read_data_1, .read_data_2, .ext_imm, .rt(ex_rt), .rd(ex_rd),
		.alu_result, .zero(em_zero), .branch_target(em_branch_target),
		.store_data(em_store_data), .dest_reg(em_dest_reg), .reg_write(em_reg_write),
		.mem_to_reg(em_mem_to_reg), .mem_read(em_mem_read), .mem_write(em_mem_write),
		.branch(em_branch));

	memory_access mem_stage (.clk, .reset, .alu_result, .zero(em_zero),
		.store_data(em_store_data), .dest_reg(em_dest_reg), .reg_write(em_reg_write),
		.mem_to_reg(em_mem_to_reg), .mem_read(em_mem_read), .mem_write(em_mem_write),
		.branch(em_branch), .pc_src, .wb_data, .wb_reg, .wb_write);

endmodule

`default_nettype wire

/* source/main_control.sv */
`timescale 1ns/1ps
`default_nettype none

module main_control (
	input  logic [5:0] opcode,
	output logic       reg_dest,
	output logic       branch,
	output logic       mem_read,
	output logic       mem_to_reg,
	output logic       mem_write,
	output logic       alu_src,
	output logic       reg_write,
	output logic [1:0] alu_op
);
	import mips_pkg::*;

	always_comb begin
		reg_dest   = 1'b0; // Unsupported opcodes fall through as nop
		branch     = 1'b0;
		mem_read   = 1'b0;
		mem_to_reg = 1'b0;
		mem_write  = 1'b0;
		alu_src    = 1'b0;
		reg_write  = 1'b0;
		alu_op     = ALUOP_MEM;
		case (opcode)
			OP_RTYPE: begin
				reg_dest  = 1'b1;
				reg_write = 1'b1;
				alu_op    = ALUOP_FUNCT;
			end
			OP_LW: begin
				alu_src    = 1'b1;
				mem_read   = 1'b1;
				mem_to_reg = 1'b1;
				reg_write  = 1'b1;
			end
			OP_SW: begin
				alu_src   = 1'b1;
				mem_write = 1'b1;
			end
			OP_BEQ: begin
				branch = 1'b1;
				alu_op = ALUOP_BEQ;
			end
			OP_ADDI: begin
				alu_src   = 1'b1;
				reg_write = 1'b1;
				alu_op    = ALUOP_ADDI;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* source/memory_access.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_access (
	input  logic        clk,
	input  logic        reset,
	input  logic [31:0] alu_result,
	input  logic        zero,
	input  logic [31:0] store_data,
	input  logic [4:0]  dest_reg,
	input  logic        reg_write,
	input  logic        mem_to_reg,
	input  logic        mem_read,
	input  logic        mem_write,
	input  logic        branch,
	output logic        pc_src,
	output logic [31:0] wb_data,
	output logic [4:0]  wb_reg,
	output logic        wb_write
);
	import mips_pkg::*;

	logic [31:0]                   dmem [DMEM_WORDS];
	logic [$clog2(DMEM_WORDS)-1:0] dmem_addr;
	logic [31:0]                   wb_read_data;
	logic [31:0]                   wb_alu_result;
	logic                          wb_mem_to_reg;

	assign dmem_addr = alu_result[11:2]; // Word addressed
	assign pc_src    = branch & zero;    // beq resolves here

	always_ff @(posedge clk) begin
		if (mem_write)
			dmem[dmem_addr] <= store_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_read_data  <= '0;
			wb_alu_result <= '0;
			wb_reg        <= '0;
			wb_write      <= 1'b0;
			wb_mem_to_reg <= 1'b0;
		end else begin
			if (mem_read)
				wb_read_data <= dmem[dmem_addr]; // Load data into MEM/WB
			wb_alu_result <= alu_result;
			wb_reg        <= dest_reg;
			wb_write      <= reg_write;
			wb_mem_to_reg <= mem_to_reg;
		end
	end

	assign wb_data = wb_mem_to_reg ? wb_read_data : wb_alu_result;

	// Decoded from one opcode two stages earlier
	mem_rw_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(mem_read && mem_write))
		else $error("Data memory read and write in the same cycle");

endmodule

`default_nettype wire

/* source/mips_pkg.sv */
`default_nettype none

package mips_pkg;

	localparam int IMEM_BYTES = 256;
	localparam int DMEM_WORDS = 1024;
	localparam int NUM_REGS   = 32;

	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_ADDI  = 6'h08;

	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR  = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	localparam logic [2:0] ALU_AND = 3'b000;
	localparam logic [2:0] ALU_OR  = 3'b001;
	localparam logic [2:0] ALU_ADD = 3'b010;
	localparam logic [2:0] ALU_SUB = 3'b110;
	localparam logic [2:0] ALU_SLT = 3'b111;

	// ALU-op classes from control to execute
	localparam logic [1:0] ALUOP_MEM   = 2'b00; // Address add for lw/sw
	localparam logic [1:0] ALUOP_BEQ   = 2'b01; // Compare by subtract
	localparam logic [1:0] ALUOP_FUNCT = 2'b10; // Decided by funct field
	localparam logic [1:0] ALUOP_ADDI  = 2'b11;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_format_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_format_t;

	typedef union packed {
		r_format_t r;
		i_format_t i;
	} instr_t;

endpackage

`default_nettype wire

/* tb/program_input.txt */
// @00 program words, one instruction per word, loaded big-endian into instruction memory
// @40 expected pairs: cycle after reset release (hex), then alu_result (hex)
@00
20010005 20020003 2006fffc 20110021 // addi r1=5, r2=3, r6=-4, r17=0x21
00221820 00222022 00222824 00223825 // add r3, sub r4, and r5, or r7
00c1402a 0026482a 00645020 200b0040 // slt r8, slt r9, add r10=r3+r4, addi r11
00000000 00000000 ad6a0004 8d6c0004 // nop, nop, sw r10,4(r11), lw r12,4(r11)
00000000 00000000 01806820 114c0005 // nop, nop, add r13=r12+r0, beq r10,r12 taken
200e0007 200f0009 2010000b 20110099 // three delay slots, skipped word
20110098 01c19020 01e29822 10220005 // skipped word, target add r18, sub r19, beq not taken
20140001 20150002 20160003 0201b820 // sequential addi r20..r22, add r23=r16+r1
00000000 0221c020                   // nop, readback add r24=r17+r1
@40
01 00000000  02 00000000  03 00000005 // pipeline flush, addi r1
04 00000003  05 fffffffc  06 00000021 // addi r2, r6, r17
07 00000008  08 00000002  09 00000001 // add, sub, and
0a 00000007  0b 00000001  0c 00000000 // or, slt with negative rs, slt false
0d 0000000a  0e 00000040  0f 00000000 // add of written regs, addi r11, nop
10 00000000  11 00000044  12 00000044 // nop, sw address, lw address
13 00000000  14 00000000  15 0000000a // nop, nop, loaded value through add
16 00000000  17 00000007  18 00000009 // beq taken, delay slots
19 0000000b  1a 0000000c  1b 00000006 // last slot, target add and sub
1c 00000002  1d 00000001  1e 00000002 // beq not taken, sequential addi
1f 00000003  20 00000010  21 00000000 // addi, add r16+r1, nop
22 00000026  23 00000000              // r17 unchanged by skipped words, trailing nop

/* tb/tb_main.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_main;
	import mips_pkg::*;

	localparam int          FILE_WORDS   = 256;
	localparam int          PROG_WORDS   = IMEM_BYTES / 4;
	localparam int          EXP_BASE     = 64; // Expected pairs start at @40 in the file
	localparam int          CLK_HALF     = 20;
	localparam int          RESET_CYCLES = 8;
	localparam int          DRIVE_DELAY  = 2;
	localparam int          SLACK_CYCLES = 20;
	localparam int          FETCH_CHECKS = 3;
	localparam logic [31:0] END_MARK     = 32'hffff_ffff;

	logic        clk;
	logic        reset;
	logic [7:0]  instruction_mem [IMEM_BYTES-1:0];
	instr_t      next_instruction;
	logic [31:0] alu_result;

	logic [31:0] input_words [FILE_WORDS];
	integer      seed;
	int          errors;
	int          checks;
	int          cycle;
	int          last_cycle;
	int          exp_idx;

	main dut (
		.clk              (clk),
		.reset            (reset),
		.instruction_mem  (instruction_mem),
		.next_instruction (next_instruction),
		.alu_result       (alu_result)
	);

	always #CLK_HALF clk = ~clk;

	// Words past the program stay zero and fetch as nop
	task automatic load_program();
		int w;
		for (w = 0; w < FILE_WORDS; w++)
			input_words[w] = (w < EXP_BASE) ? 32'd0 : END_MARK;
		$readmemh("tb/program_input.txt", input_words);
		for (w = 0; w < PROG_WORDS; w++) begin
			instruction_mem[4*w]     = input_words[w][31:24]; // Big-endian byte order
			instruction_mem[4*w + 1] = input_words[w][23:16];
			instruction_mem[4*w + 2] = input_words[w][15:8];
			instruction_mem[4*w + 3] = input_words[w][7:0];
		end
	endtask

	function automatic int find_last_cycle();
		int idx;
		int last;
		last = 0;
		idx  = EXP_BASE;
		while (idx + 1 < FILE_WORDS && input_words[idx] != END_MARK) begin
			last = input_words[idx];
			idx  = idx + 2;
		end
		return last;
	endfunction

	initial begin
		wait (last_cycle > 0);
		#((RESET_CYCLES + last_cycle + SLACK_CYCLES) * 2 * CLK_HALF);
		$display("Timeout: run did not reach its end by cycle %0d", last_cycle + SLACK_CYCLES);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		int rst_cycle;
		$timeformat(-9, 0, " ns", 0);
		seed       = 32'h7b7a;
		clk        = 1'b0;
		reset      = 1'b1;
		errors     = 0;
		checks     = 0;
		cycle      = 0;
		load_program();
		last_cycle = find_last_cycle();
		if (last_cycle == 0) begin
			errors++;
			$display("No expected results were read from tb/program_input.txt");
		end

		for (rst_cycle = 1; rst_cycle <= RESET_CYCLES; rst_cycle++) begin
			@(posedge clk);
			#DRIVE_DELAY;
			if (rst_cycle == RESET_CYCLES)
				reset = 1'b0; // Next edge fetches address 0
			@(negedge clk);
			checks++;
			if (alu_result !== 32'd0) begin
				errors++;
				$display("FAIL at %0t: alu_result is %h during reset", $time, alu_result);
			end
		end

		exp_idx = EXP_BASE;
		while (cycle < last_cycle) begin
			@(posedge clk);
			cycle++;
			@(negedge clk);
			if (cycle <= FETCH_CHECKS) begin
				checks++;
				if (next_instruction !== input_words[cycle-1]) begin
					errors++;
					$display("FAIL at %0t: fetch in cycle %0d gave %h, expected %h",
						$time, cycle, next_instruction, input_words[cycle-1]);
				end
			end
			if (input_words[exp_idx] == cycle) begin
				checks++;
				if (alu_result !== input_words[exp_idx+1]) begin
					errors++;
					$display("FAIL at %0t: alu_result in cycle %0d is %h, expected %h",
						$time, cycle, alu_result, input_words[exp_idx+1]);
				end
				exp_idx = exp_idx + 2;
			end
		end
		if (exp_idx + 1 < FILE_WORDS && input_words[exp_idx] != END_MARK) begin
			errors++;
			$display("Expected result for cycle %0d was never checked", input_words[exp_idx]);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire
